/* isaPkg.sv */
`default_nettype none

package isaPkg;

	// Register file size
	localparam int numRegs = 32;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;
	typedef logic [3:0] aluOpT;
	typedef logic [1:0] bSelT;

	// Major opcodes of the kept subset
	localparam logic [6:0] opOp = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opBranch = 7'b1100011;

	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll = 3'b001;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;

	// funct7 bit 5 separates SUB from ADD
	localparam int f7SubBit = 5;

	localparam aluOpT aluAdd = 4'd0;
	localparam aluOpT aluSub = 4'd1;
	localparam aluOpT aluAnd = 4'd2;
	localparam aluOpT aluOr = 4'd3;
	localparam aluOpT aluXor = 4'd4;
	localparam aluOpT aluSll = 4'd5;
	localparam aluOpT aluPassB = 4'd6;

	// Operand B sources
	localparam bSelT bSelReg = 2'b00;
	localparam bSelT bSelImm = 2'b01;
	localparam bSelT bSelShamt = 2'b10;

endpackage

`default_nettype wire

/* hazardPkg.sv */
`default_nettype none

package hazardPkg;

	import isaPkg::*;

	// Kill counter
	typedef logic [1:0] killCntT;

	// Cycles that kill stays high after a taken branch
	localparam killCntT killLen = 2'd2;

	// One pending bit per architectural register
	typedef logic [numRegs-1:0] pendT;

endpackage

`default_nettype wire

/* pipeIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface decIssueIf import isaPkg::*; ();
	logic valid;
	regAddrT rs1, rs2;
	regAddrT rd;
	logic we;
	aluOpT aluOp;
	bSelT bSel;
	wordT iImm;
	logic [4:0] shamt;
	logic branch, bne;
	wordT pc, bImm;

	modport src (output valid, rs1, rs2, rd, we, aluOp, bSel, iImm, shamt, branch, bne, pc, bImm);
	modport dst (input valid, rs1, rs2, rd, we, aluOp, bSel, iImm, shamt, branch, bne, pc, bImm);
endinterface

interface issueExIf import isaPkg::*; ();
	logic valid;
	regAddrT rd;
	logic we;
	aluOpT aluOp;
	wordT opA, opB, rs2Val;
	logic branch, bne;
	wordT pc, bImm;

	modport src (output valid, rd, we, aluOp, opA, opB, rs2Val, branch, bne, pc, bImm);
	modport dst (input valid, rd, we, aluOp, opA, opB, rs2Val, branch, bne, pc, bImm);
endinterface

`default_nettype wire

/* decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage import isaPkg::*; (
	input wire logic clk,
	input wire logic nrst,
	input wordT instr,
	output wordT pc,
	input wire logic stall,
	input wire logic branchTaken,
	input wordT branchTarget,
	decIssueIf.src dec
);

	wordT pcQ;
	logic nWe, nBranch;
	regAddrT nRs1, nRs2;
	aluOpT nAlu;
	bSelT nBSel;
	wordT nImm, bImm;

	assign pc = pcQ;
	assign bImm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	always_comb
	begin
		nWe = 1'b0;
		nBranch = 1'b0;
		nRs1 = '0;
		nRs2 = '0;
		nAlu = aluAdd;
		nBSel = bSelReg;
		nImm = {{20{instr[31]}}, instr[31:20]};
		unique case (instr[6:0])
			opOp:
			begin
				nRs1 = instr[19:15];
				nRs2 = instr[24:20];
				nWe = 1'b1;
				case (instr[14:12])
					f3AddSub: nAlu = instr[25 + f7SubBit] ? aluSub : aluAdd;
					f3Xor: nAlu = aluXor;
					f3Or: nAlu = aluOr;
					f3And: nAlu = aluAnd;
					default: nWe = 1'b0;
				endcase
			end
			opImm:
			begin
				nRs1 = instr[19:15];
				nWe = 1'b1;
				case (instr[14:12])
					f3AddSub: nBSel = bSelImm;
					f3Sll:
					begin
						nAlu = aluSll;
						nBSel = bSelShamt;
					end
					default: nWe = 1'b0;
				endcase
			end
			opLui:
			begin
				// U-immediate rides in the I-immediate slot
				nWe = 1'b1;
				nAlu = aluPassB;
				nBSel = bSelImm;
				nImm = {instr[31:12], 12'b0};
			end
			opBranch:
			begin
				nRs1 = instr[19:15];
				nRs2 = instr[24:20];
				nBranch = (instr[14:12] == f3Beq) || (instr[14:12] == f3Bne);
			end
			default: ;
		endcase
		// No write-back for x0
		if (instr[11:7] == '0)
			nWe = 1'b0;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pcQ <= '0;
			dec.valid <= 1'b0;
			dec.we <= 1'b0;
			dec.branch <= 1'b0;
		end
		else if (branchTaken)
		begin
			pcQ <= branchTarget;
			dec.valid <= 1'b0;
			dec.we <= 1'b0;
			dec.branch <= 1'b0;
		end
		else if (!stall)
		begin
			pcQ <= pcQ + 32'd4;
			dec.valid <= 1'b1;
			dec.we <= nWe;
			dec.branch <= nBranch;
		end
	end

	// Payload fields hold with the slot
	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			dec.rs1 <= nRs1;
			dec.rs2 <= nRs2;
			dec.rd <= instr[11:7];
			dec.aluOp <= nAlu;
			dec.bSel <= nBSel;
			dec.iImm <= nImm;
			dec.shamt <= instr[24:20];
			dec.bne <= (instr[14:12] == f3Bne);
			dec.pc <= pcQ;
			dec.bImm <= bImm;
		end
	end

endmodule

`default_nettype wire

/* scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module scoreboard import isaPkg::*; import hazardPkg::*; (
	input wire logic clk,
	input wire logic nrst,
	input regAddrT rs1,
	input regAddrT rs2,
	input wire logic decValid,
	input regAddrT issueRd,
	input wire logic issueWe,
	input wire logic wbValid,
	input regAddrT wbRd,
	input wire logic branchTaken,
	output logic stall,
	output logic kill
);

	pendT pending, pendNext;
	killCntT killCnt;
	logic hitA, hitB;

	// Busy if waiting in execute or about to leave issue
	always_comb
	begin
		hitA = (rs1 != '0) && ((pending[rs1] && !(wbValid && wbRd == rs1))
			|| (issueWe && issueRd == rs1));
		hitB = (rs2 != '0) && ((pending[rs2] && !(wbValid && wbRd == rs2))
			|| (issueWe && issueRd == rs2));
		stall = decValid && (hitA || hitB);
	end

	assign kill = branchTaken || (killCnt != '0);

	always_comb
	begin
		pendNext = pending;
		if (wbValid)
			pendNext[wbRd] = 1'b0;
		// A killed slot never marks its destination
		if (issueWe && !kill)
			pendNext[issueRd] = 1'b1;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pending <= '0;
			killCnt <= '0;
		end
		else
		begin
			pending <= pendNext;
			if (branchTaken)
				killCnt <= killCntT'(killLen - 2'd1);
			else if (killCnt != '0)
				killCnt <= killCnt - 2'd1;
		end
	end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import isaPkg::*; (
	input wire logic clk,
	input wire logic nrst,
	input wire logic we,
	input regAddrT wAddr,
	input wordT wData,
	input regAddrT rAddrA,
	input regAddrT rAddrB,
	output wordT rDataA,
	output wordT rDataB
);

	wordT regs [numRegs];

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end
		else if (we && wAddr != '0)
			regs[wAddr] <= wData;
	end

	// Write-through so a same-cycle write-back is seen
	always_comb
	begin
		if (rAddrA == '0)
			rDataA = '0;
		else if (we && wAddr == rAddrA)
			rDataA = wData;
		else
			rDataA = regs[rAddrA];
		if (rAddrB == '0)
			rDataB = '0;
		else if (we && wAddr == rAddrB)
			rDataB = wData;
		else
			rDataB = regs[rAddrB];
	end

endmodule

`default_nettype wire

/* issueStage.sv */
`timescale 1ns/1ps
`default_nettype none

module issueStage import isaPkg::*; (
	input wire logic clk,
	input wire logic nrst,
	decIssueIf.dst dec,
	input wire logic stall,
	input wire logic kill,
	input wordT rDataA,
	input wordT rDataB,
	issueExIf.src ex
);

	logic validQ, weQ, branchQ, bneQ;
	regAddrT rdQ;
	aluOpT aluQ;
	bSelT bSelQ;
	wordT iImmQ, pcQ, bImmQ, valA, valB;
	logic [4:0] shamtQ;

	// Bubble on stall or kill
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			validQ <= 1'b0;
			weQ <= 1'b0;
			branchQ <= 1'b0;
		end
		else if (stall || kill)
		begin
			validQ <= 1'b0;
			weQ <= 1'b0;
			branchQ <= 1'b0;
		end
		else
		begin
			validQ <= dec.valid;
			weQ <= dec.we;
			branchQ <= dec.branch;
		end
	end

	always_ff @(posedge clk)
	begin
		rdQ <= dec.rd;
		aluQ <= dec.aluOp;
		bSelQ <= dec.bSel;
		iImmQ <= dec.iImm;
		shamtQ <= dec.shamt;
		bneQ <= dec.bne;
		pcQ <= dec.pc;
		bImmQ <= dec.bImm;
		valA <= rDataA;
		valB <= rDataB;
	end

	always_comb
	begin
		unique case (bSelQ)
			bSelReg: ex.opB = valB;
			bSelImm: ex.opB = iImmQ;
			bSelShamt: ex.opB = {27'b0, shamtQ};
			default: ex.opB = valB;
		endcase
	end

	assign ex.valid = validQ;
	assign ex.we = weQ;
	assign ex.rd = rdQ;
	assign ex.aluOp = aluQ;
	assign ex.opA = valA;
	assign ex.rs2Val = valB;
	assign ex.branch = branchQ;
	assign ex.bne = bneQ;
	assign ex.pc = pcQ;
	assign ex.bImm = bImmQ;

endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage import isaPkg::*; (
	input wire logic clk,
	input wire logic nrst,
	issueExIf.dst ex,
	output logic branchTaken,
	output wordT branchTarget,
	output logic wbValid,
	output regAddrT wbRd,
	output wordT wbData
);

	logic validQ, weQ, branchQ, bneQ, eq;
	regAddrT rdQ;
	aluOpT aluQ;
	wordT opA, opB, rs2Val, pcQ, bImmQ, result;

	// The slot behind a taken branch enters as a bubble
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			validQ <= 1'b0;
			weQ <= 1'b0;
			branchQ <= 1'b0;
		end
		else if (branchTaken)
		begin
			validQ <= 1'b0;
			weQ <= 1'b0;
			branchQ <= 1'b0;
		end
		else
		begin
			validQ <= ex.valid;
			weQ <= ex.we;
			branchQ <= ex.branch;
		end
	end

	always_ff @(posedge clk)
	begin
		rdQ <= ex.rd;
		aluQ <= ex.aluOp;
		opA <= ex.opA;
		opB <= ex.opB;
		rs2Val <= ex.rs2Val;
		bneQ <= ex.bne;
		pcQ <= ex.pc;
		bImmQ <= ex.bImm;
	end

	always_comb
	begin
		unique case (aluQ)
			aluAdd: result = opA + opB;
			aluSub: result = opA - opB;
			aluAnd: result = opA & opB;
			aluOr: result = opA | opB;
			aluXor: result = opA ^ opB;
			aluSll: result = opA << opB[4:0];
			aluPassB: result = opB;
			default: result = '0;
		endcase
	end

	assign eq = (opA == rs2Val);
	assign branchTaken = validQ && branchQ && (bneQ ? !eq : eq);
	assign branchTarget = pcQ + bImmQ;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			wbValid <= 1'b0;
		else
			wbValid <= validQ && weQ;
	end

	always_ff @(posedge clk)
	begin
		wbRd <= rdQ;
		wbData <= result;
	end

endmodule

`default_nettype wire

/* coreTop.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTop import isaPkg::*; (
	input wire logic clk,
	input wire logic nrst,
	output wordT pc,
	input wordT instr,
	output logic wbValid,
	output regAddrT wbRd,
	output wordT wbData,
	output logic stall
);

	logic kill, branchTaken;
	wordT branchTarget, rDataA, rDataB;

	decIssueIf dec ();
	issueExIf ex ();

	decodeStage uDecode (.clk(clk), .nrst(nrst), .instr(instr), .pc(pc), .stall(stall),
		.branchTaken(branchTaken), .branchTarget(branchTarget), .dec(dec.src));

	// Slot in the issue register is the one leaving toward execute
	scoreboard uScoreboard (.clk(clk), .nrst(nrst), .rs1(dec.rs1), .rs2(dec.rs2),
		.decValid(dec.valid), .issueRd(ex.rd), .issueWe(ex.valid && ex.we),
		.wbValid(wbValid), .wbRd(wbRd), .branchTaken(branchTaken), .stall(stall), .kill(kill));

	regFile uRegFile (.clk(clk), .nrst(nrst), .we(wbValid), .wAddr(wbRd), .wData(wbData),
		.rAddrA(dec.rs1), .rAddrB(dec.rs2), .rDataA(rDataA), .rDataB(rDataB));

	issueStage uIssue (.clk(clk), .nrst(nrst), .dec(dec.dst), .stall(stall), .kill(kill),
		.rDataA(rDataA), .rDataB(rDataB), .ex(ex.src));

	executeStage uExecute (.clk(clk), .nrst(nrst), .ex(ex.dst), .branchTaken(branchTaken),
		.branchTarget(branchTarget), .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData));

endmodule

`default_nettype wire

/* core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module coreChk import isaPkg::*; (
	input wire logic clk,
	input wire logic nrst,
	input wire logic stall,
	input wire logic kill,
	input wire logic wbValid,
	input regAddrT wbRd
);

	// A dependency waits at most while its producer sits in issue and execute
	stallBounded: assert property (@(posedge clk) disable iff (!nrst)
		!(stall && $past(stall) && $past(stall, 2)))
		else $error("stall held longer than two cycles");

	wbNotZero: assert property (@(posedge clk) disable iff (!nrst)
		wbValid |-> wbRd != '0)
		else $error("write-back reported for x0");

	// Slots flushed by a taken branch never reach write-back
	killQuiet: assert property (@(posedge clk) disable iff (!nrst)
		kill |=> !wbValid)
		else $error("write-back in the cycle after a kill cycle");

endmodule

`default_nettype wire

/* coreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTb import isaPkg::*; ();

	localparam int halfPeriod = 20;
	localparam int drvDelay = 2;
	localparam int resetCycles = 8;
	localparam int drainCycles = 10;
	localparam wordT nopWord = 32'h00000013;

	// Instruction kinds of the program table
	localparam int kAdd = 0;
	localparam int kSub = 1;
	localparam int kAnd = 2;
	localparam int kOr = 3;
	localparam int kXor = 4;
	localparam int kAddi = 5;
	localparam int kSlli = 6;
	localparam int kLui = 7;
	localparam int kBeq = 8;
	localparam int kBne = 9;

	logic clk;
	logic nrst;
	wordT pc, instr, wbData;
	regAddrT wbRd;
	logic wbValid, stall;

	int progKind[$];
	int progRd[$];
	int progRs1[$];
	int progRs2[$];
	int progImm[$];
	wordT progWord[$];
	regAddrT expRd[$];
	wordT expData[$];
	int cycleCount;
	int timeoutLimit;
	bit passed;
	bit failReported;

	coreTop UUT (.clk(clk), .nrst(nrst), .pc(pc), .instr(instr), .wbValid(wbValid),
		.wbRd(wbRd), .wbData(wbData), .stall(stall));

	bind coreTop coreChk chk (.clk(clk), .nrst(nrst), .stall(stall), .kill(kill),
		.wbValid(wbValid), .wbRd(wbRd));

	task automatic abortRun(input string msg);
		failReported = 1'b1;
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	// Instruction formats from the base ISA
	function automatic wordT encode(int kind, int rd, int rs1, int rs2, int imm);
		logic [4:0] d, s1, s2;
		logic [31:0] i;
		d = 5'(rd);
		s1 = 5'(rs1);
		s2 = 5'(rs2);
		i = imm;
		case (kind)
			kAdd: return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
			kSub: return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
			kAnd: return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
			kOr: return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
			kXor: return {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
			kAddi: return {i[11:0], s1, 3'b000, d, 7'b0010011};
			kSlli: return {7'b0000000, i[4:0], s1, 3'b001, d, 7'b0010011};
			kLui: return {i[19:0], d, 7'b0110111};
			kBeq: return {i[12], i[10:5], s2, s1, 3'b000, i[4:1], i[11], 7'b1100011};
			kBne: return {i[12], i[10:5], s2, s1, 3'b001, i[4:1], i[11], 7'b1100011};
			default: return nopWord;
		endcase
	endfunction

	task automatic addInstr(input int kind, input int rd, input int rs1, input int rs2,
		input int imm);
		progKind.push_back(kind);
		progRd.push_back(rd);
		progRs1.push_back(rs1);
		progRs2.push_back(rs2);
		progImm.push_back(imm);
		progWord.push_back(encode(kind, rd, rs1, rs2, imm));
	endtask

	// kind, rd, rs1, rs2, imm (branch offsets in bytes, LUI takes the upper 20 bits)
	task automatic loadProgram();
		addInstr(kAddi, 1, 0, 0, 5);
		addInstr(kAddi, 2, 0, 0, -3);
		addInstr(kLui, 3, 0, 0, 'h12345);
		addInstr(kAddi, 4, 0, 0, 'hf0);
		addInstr(kAddi, 0, 0, 0, 7);
		addInstr(kAdd, 5, 1, 2, 0);
		addInstr(kSub, 6, 1, 5, 0);
		addInstr(kAnd, 7, 2, 4, 0);
		addInstr(kOr, 8, 3, 1, 0);
		addInstr(kXor, 9, 8, 2, 0);
		addInstr(kSlli, 10, 1, 0, 4);
		addInstr(kAdd, 11, 0, 10, 0);
		addInstr(kBeq, 0, 1, 5, 8);
		addInstr(kAddi, 13, 11, 0, 1);
		addInstr(kBne, 0, 1, 13, 12);
		addInstr(kAddi, 14, 0, 0, 99);
		addInstr(kAddi, 15, 0, 0, 98);
		addInstr(kAddi, 16, 0, 0, 1);
		addInstr(kBeq, 0, 16, 16, 12);
		addInstr(kAddi, 17, 0, 0, 77);
		addInstr(kAddi, 18, 0, 0, 66);
		addInstr(kSub, 19, 0, 16, 0);
		addInstr(kAddi, 20, 19, 0, 'h7ff);
		addInstr(kLui, 21, 0, 0, 'hfffff);
		addInstr(kXor, 22, 21, 19, 0);
		addInstr(kBne, 0, 22, 22, 8);
		addInstr(kOr, 23, 22, 0, 0);
		addInstr(kAddi, 0, 23, 0, 1);
		addInstr(kAdd, 24, 0, 0, 0);
	endtask

	// Walks the table in program order and queues every architectural write
	task automatic runModel();
		wordT regs [32];
		wordT a, b, v, imm;
		int idx;
		bit wr;
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		idx = 0;
		while (idx < progKind.size())
		begin
			a = regs[progRs1[idx]];
			b = regs[progRs2[idx]];
			imm = progImm[idx];
			wr = 1'b1;
			v = '0;
			case (progKind[idx])
				kAdd: v = a + b;
				kSub: v = a - b;
				kAnd: v = a & b;
				kOr: v = a | b;
				kXor: v = a ^ b;
				kAddi: v = a + {{20{imm[11]}}, imm[11:0]};
				kSlli: v = a << imm[4:0];
				kLui: v = {imm[19:0], 12'h000};
				default: wr = 1'b0;
			endcase
			if (wr && progRd[idx] != 0)
			begin
				regs[progRd[idx]] = v;
				expRd.push_back(5'(progRd[idx]));
				expData.push_back(v);
			end
			if ((progKind[idx] == kBeq && a == b) || (progKind[idx] == kBne && a != b))
				idx = idx + progImm[idx] / 4;
			else
				idx = idx + 1;
		end
	endtask

	function automatic wordT fetchWord(wordT addr);
		int idx;
		idx = int'(addr >> 2);
		if (idx < progWord.size())
			return progWord[idx];
		return nopWord;
	endfunction

	task automatic checkIdle(input string when);
		assert (pc == '0)
		else
			abortRun($sformatf("ERR pc %s: got %h, expected %h", when, pc, 32'h0));
		assert (!wbValid)
		else
			abortRun($sformatf("ERR wbValid %s: got %h, expected %h", when, wbValid, 1'b0));
		assert (!stall)
		else
			abortRun($sformatf("ERR stall %s: got %h, expected %h", when, stall, 1'b0));
	endtask

	task automatic checkWrite();
		regAddrT rd;
		wordT data;
		assert (expRd.size() != 0)
		else
			abortRun($sformatf("write-back to x%0d after all expected writes retired", wbRd));
		rd = expRd.pop_front();
		data = expData.pop_front();
		assert (wbRd == rd)
		else
			abortRun($sformatf("ERR wbRd: got %h, expected %h", wbRd, rd));
		assert (wbData == data)
		else
			abortRun($sformatf("ERR wbData: got %h, expected %h (x%0d)", wbData, data, rd));
	endtask

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Answers the pc shortly after each rising edge
	initial
	begin
		instr = nopWord;
		forever
		begin
			@(posedge clk);
			#drvDelay;
			instr = fetchWord(pc);
		end
	end

	always @(negedge clk)
	begin
		if (nrst && wbValid)
			checkWrite();
	end

	always @(posedge clk)
	begin
		if (nrst)
		begin
			cycleCount = cycleCount + 1;
			if (cycleCount > timeoutLimit)
				abortRun($sformatf("timeout after %0d cycles with %0d writes outstanding",
					cycleCount, expRd.size()));
		end
	end

	initial
	begin
		nrst = 1'b0;
		cycleCount = 0;
		passed = 1'b0;
		failReported = 1'b0;
		loadProgram();
		runModel();
		timeoutLimit = progKind.size() * 8 + 50;
		repeat (resetCycles)
		begin
			@(negedge clk);
			checkIdle("during reset");
		end
		@(posedge clk);
		#drvDelay;
		nrst = 1'b1;
		@(negedge clk);
		checkIdle("after reset");
		while (expRd.size() != 0)
			@(negedge clk);
		// Stray write-backs would still show up here
		repeat (drainCycles)
			@(negedge clk);
		passed = 1'b1;
		$display("Everything OK");
		$finish;
	end

	final
	begin
		if (!passed && !failReported)
			$display("Something failed");
	end

endmodule

`default_nettype wire

/* src.f */
isaPkg.sv
hazardPkg.sv
pipeIf.sv
decodeStage.sv
scoreboard.sv
regFile.sv
issueStage.sv
executeStage.sv
coreTop.sv
core_chk.sv
coreTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module coreTb \
	-f src.f --Mdir obj_dir -o coreSim
out=$(./obj_dir/coreSim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Everything OK"
then
	exit 0
fi
exit 1
